// File: project.f
+incdir+rtl
rtl/spi_dio_pkg.sv
rtl/sfr_pack.sv
rtl/spi_engine.sv
rtl/dio_bridge.sv
rtl/spi_dio_pack.sv
testbench/spi_dio_slave.sv
testbench/tb_spi_dio_pack.sv

// File: rtl/dio_bridge.sv
module dio_bridge
    import spi_dio_pkg::*;
(
    input  logic   clk,
    input  logic   rst_n,
    input  nbits_t nbits,
    input  logic   ss,
    input  logic   sck,
    input  logic   mosi,
    output logic   miso,
    inout  wire    dio
);

    logic       sck_q;
    logic       ss_q;
    logic [6:0] tgl_cnt;                // SCK toggles since SS fell
    nbits_t     n_eff;
    logic [5:0] bit_idx;
    logic       oe;

    assign n_eff = (nbits == '0) ? nbits_t'(32) : nbits;

    // Sampled on clk, one cycle behind the engine
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sck_q   <= 1'b0;
            ss_q    <= 1'b1;
            tgl_cnt <= '0;
        end else begin
            sck_q <= sck;
            ss_q  <= ss;
            if (ss_q) begin
                tgl_cnt <= '0;
            end else if ((sck != sck_q) && (tgl_cnt != 7'h7f)) begin
                tgl_cnt <= tgl_cnt + 7'd1;                  // Saturates, never wraps to drive again
            end
        end
    end

    assign bit_idx = tgl_cnt[6:1];      // Two toggles per bit
    assign oe      = !ss_q && (bit_idx < n_eff);

    assign dio  = oe ? mosi : 1'bz;     // Released after the write phase
    assign miso = dio;                  // Pin level, driven or not

endmodule

// File: rtl/sfr_pack.sv
`include "spi_dio_params.svh"

module sfr_pack
    import spi_dio_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  mem_fwd_t mem_fwd,
    output mem_ret_t mem_ret,
    input  word_t    rd_data_reg,       // Read value at base
    input  word_t    rd_cfg_reg,        // Read value at base + 4
    output word_t    data_reg,
    output spi_cfg_t cfg_reg,
    output logic     wr_start
);

    logic  hit;
    logic  accept;
    logic  is_data;
    logic  is_cfg;
    logic  answered;                    // Set once the current valid got its reply
    logic  ready_q;
    logic  start_q;
    word_t rdata_q;
    word_t data_q;
    word_t cfg_q;

    // ----------------------------------------
    // Decode
    // ----------------------------------------
    assign hit     = mem_fwd.valid && (mem_fwd.addr[31:24] == `SPI_BASE_ADDR);
    assign accept  = hit && !answered;  // First cycle of a new access
    assign is_data = (mem_fwd.addr[2] == `SPI_REG_DATA);
    assign is_cfg  = (mem_fwd.addr[2] == `SPI_REG_CFG);

    // ----------------------------------------
    // Handshake and registers
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            answered <= 1'b0;
            ready_q  <= 1'b0;
            start_q  <= 1'b0;
            data_q   <= '0;
            cfg_q    <= `SPI_CFG_RESET;
        end else begin
            ready_q <= accept;                              // One-cycle reply
            start_q <= accept && is_data && mem_fwd.wstrb[0];
            if (!mem_fwd.valid) begin
                answered <= 1'b0;                           // Re-arm after valid drops
            end else if (accept) begin
                answered <= 1'b1;
            end
            // Byte-wise writes, a read has no strobes
            if (accept) begin
                for (int b = 0; b < 4; b++) begin
                    if (mem_fwd.wstrb[b]) begin
                        if (is_cfg) begin
                            cfg_q[8*b +: 8] <= mem_fwd.wdata[8*b +: 8];
                        end else begin
                            data_q[8*b +: 8] <= mem_fwd.wdata[8*b +: 8];
                        end
                    end
                end
            end
        end
    end

    // Read mux, captured together with ready
    always_ff @(posedge clk) begin
        if (accept) begin
            rdata_q <= is_cfg ? rd_cfg_reg : rd_data_reg;
        end
    end

    assign mem_ret.ready = ready_q;
    assign mem_ret.rdata = rdata_q;
    assign data_reg      = data_q;
    assign cfg_reg       = spi_cfg_t'(cfg_q);
    assign wr_start      = start_q;     // Same cycle as ready, data_reg already updated

endmodule

// File: rtl/spi_dio_pack.sv
module spi_dio_pack
    import spi_dio_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  mem_fwd_t mem_fwd,           // CPU to SPI
    output mem_ret_t mem_ret,           // SPI to CPU
    output logic     spi_ss,
    output logic     spi_sck,
    inout  wire      spi_dio
);

    word_t    data_reg;
    word_t    rx_word;
    spi_cfg_t cfg_reg;
    spi_cfg_t cfg_rd;                   // Config as read back
    logic     wr_start;
    logic     busy;
    logic     ss_auto;
    logic     mosi;
    logic     miso;

    // ----------------------------------------
    // Register file
    // ----------------------------------------
    sfr_pack u_sfr (
        .clk         (clk),
        .rst_n       (rst_n),
        .mem_fwd     (mem_fwd),
        .mem_ret     (mem_ret),
        .rd_data_reg (rx_word),         // Data read returns the last reception
        .rd_cfg_reg  (word_t'(cfg_rd)),
        .data_reg    (data_reg),
        .cfg_reg     (cfg_reg),
        .wr_start    (wr_start)
    );

    // Top two bits come from live status only
    always_comb begin
        cfg_rd      = cfg_reg;
        cfg_rd.busy = busy;
        cfg_rd.miso = miso;
    end

    // Manual or automatic SS
    assign spi_ss = cfg_reg.ss_man ? cfg_reg.ss_ctrl : ss_auto;

    // ----------------------------------------
    // Engine and pin bridge
    // ----------------------------------------
    spi_engine u_engine (
        .clk     (clk),
        .rst_n   (rst_n),
        .start   (wr_start),
        .tx_word (data_reg),
        .rx_word (rx_word),
        .busy    (busy),
        .clk_div (cfg_reg.clk_div),
        .nbits   (cfg_reg.nbits),
        .cpol    (cfg_reg.cpol),
        .cpha    (cfg_reg.cpha),
        .lsb     (cfg_reg.lsb),
        .ss_auto (ss_auto),
        .sck     (spi_sck),
        .mosi    (mosi),
        .miso    (miso)
    );

    dio_bridge u_bridge (
        .clk   (clk),
        .rst_n (rst_n),
        .nbits (cfg_reg.nbits),
        .ss    (spi_ss),                // Counts against the pin SS, manual or not
        .sck   (spi_sck),
        .mosi  (mosi),
        .miso  (miso),
        .dio   (spi_dio)
    );

endmodule

// File: rtl/spi_dio_params.svh
`ifndef SPI_DIO_PARAMS_SVH
`define SPI_DIO_PARAMS_SVH

// ----------------------------------------
// Address map
// ----------------------------------------

// Compared with bus address bits 31:24
`define SPI_BASE_ADDR   8'h40

// Register index, taken from address bit 2
`define SPI_REG_DATA    1'b0    // Data register at base
`define SPI_REG_CFG     1'b1    // Config register at base + 4

// ----------------------------------------
// Config register after reset
// ----------------------------------------

// Divider 0, 8 bits, mode 0, MSB first, automatic SS
`define SPI_CFG_RESET   32'h0000_0800

`endif

// File: rtl/spi_dio_pkg.sv
package spi_dio_pkg;

    typedef logic [31:0] word_t;        // CPU data word
    typedef logic [7:0]  sck_div_t;     // d gives d+1 clk cycles per SCK half period
    typedef logic [5:0]  nbits_t;       // Bits per transfer, 0 means 32

    // PicoRV32 packed bus, CPU to peripheral
    typedef struct packed {
        logic        valid;
        logic [3:0]  wstrb;
        word_t       addr;
        word_t       wdata;
    } mem_fwd_t;

    // Peripheral back to CPU
    typedef struct packed {
        logic        ready;
        word_t       rdata;
    } mem_ret_t;

    // Config register layout
    typedef struct packed {
        logic        miso;              // Live pin level, read only
        logic        busy;              // Engine busy, read only
        logic [2:0]  rsvd_29_27;
        logic        ss_ctrl;           // SS level in manual mode
        logic        ss_man;            // 1 = manual SS
        logic [5:0]  rsvd_24_19;
        logic        lsb;               // 1 = LSB first
        logic        cpha;
        logic        cpol;              // SCK idle level
        logic [1:0]  rsvd_15_14;
        nbits_t      nbits;
        sck_div_t    clk_div;
    } spi_cfg_t;

    // Engine phases
    typedef enum logic [1:0] {
        IDLE,
        LEAD,
        SHIFT,
        TRAIL
    } spi_state_t;

endpackage

// File: rtl/spi_engine.sv
module spi_engine
    import spi_dio_pkg::*;
(
    input  logic     clk,
    input  logic     rst_n,
    input  logic     start,             // Ignored unless idle
    input  word_t    tx_word,
    output word_t    rx_word,           // Right-aligned reception
    output logic     busy,
    input  sck_div_t clk_div,
    input  nbits_t   nbits,
    input  logic     cpol,
    input  logic     cpha,
    input  logic     lsb,
    output logic     ss_auto,
    output logic     sck,
    output logic     mosi,
    input  logic     miso
);

    spi_state_t state;
    sck_div_t   div_cnt;                // Half-period timer
    logic [6:0] edge_cnt;               // SCK edge index, up to 63
    logic       sck_tgl;                // SCK relative to cpol
    logic       mosi_q;
    word_t      sreg;                   // TX out at one end, RX in at the other

    nbits_t     n_eff;
    nbits_t     pad;                    // Unused bit positions, 32 - n_eff
    logic [6:0] last_edge;
    logic       tick;
    logic       edge_now;
    logic       smp_edge;
    word_t      ld_word;
    logic       out_bit;

    // ----------------------------------------
    // Transfer geometry
    // ----------------------------------------
    assign n_eff     = (nbits == '0) ? nbits_t'(32) : nbits;
    assign pad       = nbits_t'(32) - n_eff;
    assign last_edge = {n_eff, 1'b0} - 7'd1;           // 2*n edges, numbered from 0

    assign tick      = (div_cnt == clk_div);           // End of a half period
    assign edge_now  = tick && ((state == LEAD) || (state == SHIFT));
    // cpha 0 samples on even edges, cpha 1 on odd ones
    assign smp_edge  = (edge_cnt[0] == cpha);

    // MSB first puts bit n-1 at bit 31, LSB first leaves bit 0 in place
    assign ld_word   = lsb ? tx_word : (tx_word << pad);
    assign out_bit   = lsb ? sreg[0] : sreg[31];

    // ----------------------------------------
    // Phase control
    // ----------------------------------------
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state    <= IDLE;
            div_cnt  <= '0;
            edge_cnt <= '0;
            sck_tgl  <= 1'b0;
            rx_word  <= '0;
        end else begin
            case (state)
                IDLE: begin
                    div_cnt  <= '0;
                    edge_cnt <= '0;
                    sck_tgl  <= 1'b0;
                    if (start) begin
                        state <= LEAD;                      // SS drops here
                    end
                end
                LEAD, SHIFT: begin
                    if (tick) begin
                        div_cnt  <= '0;
                        sck_tgl  <= ~sck_tgl;               // Lead ends with edge 0
                        edge_cnt <= edge_cnt + 7'd1;
                        state    <= (edge_cnt == last_edge) ? TRAIL : SHIFT;
                    end else begin
                        div_cnt <= div_cnt + 8'd1;
                    end
                end
                TRAIL: begin
                    if (tick) begin
                        div_cnt <= '0;
                        state   <= IDLE;
                        // MSB first is already aligned, upper bits shifted out as zeros
                        rx_word <= lsb ? (sreg >> pad) : sreg;
                    end else begin
                        div_cnt <= div_cnt + 8'd1;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    // ----------------------------------------
    // Shift path
    // ----------------------------------------
    always_ff @(posedge clk) begin
        if ((state == IDLE) && start) begin
            sreg   <= ld_word;
            mosi_q <= lsb ? ld_word[0] : ld_word[31];       // First bit ready before edge 0
        end else if (edge_now) begin
            if (smp_edge) begin
                // Move one place, sampled bit enters behind
                sreg <= lsb ? {miso, sreg[31:1]} : {sreg[30:0], miso};
            end else begin
                mosi_q <= out_bit;                          // Present next bit
            end
        end
    end

    assign busy    = (state != IDLE);
    assign ss_auto = (state == IDLE);   // Low exactly while busy
    assign sck     = cpol ^ sck_tgl;    // Even edge count brings it back to idle
    assign mosi    = mosi_q;

endmodule

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    -f project.f --top-module tb_spi_dio_pack -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log

if grep -q "Simulation failed" sim.log; then
    exit 1
fi
grep -q "Simulation completed successfully" sim.log

// File: testbench/spi_dio_slave.sv
module spi_dio_slave (
    input  logic ss,
    input  logic sck,
    inout  wire  dio,
    input  logic cpol,
    input  logic cpha,
    input  logic lsb,
    input  int   nbits                  // 1 to 32
);
    timeunit 1ns;
    timeprecision 100ps;

    localparam logic [31:0] PATTERN = 32'hA5C3_0F96;   // Returned in the read phase

    logic [31:0] capture;               // Bits seen in the write phase
    logic        oe;
    logic        dval;
    logic        ss_q;
    logic        sck_q;
    int          edges;                 // SCK edges since SS fell

    assign dio = oe ? dval : 1'bz;

    // One SCK edge, handled a little after the edge so the pin has settled
    task automatic take_edge();
        logic first;
        int   bit_i;
        int   nxt;
        int   idx;
        first = (sck_q != cpol);        // Leaving the idle level starts a bit
        bit_i = edges / 2;
        edges++;
        if (first ^ cpha) begin
            if (bit_i < nbits) begin
                if (lsb) begin
                    capture[bit_i] = dio;
                end else begin
                    capture = {capture[30:0], dio};
                end
            end
        end else begin
            nxt = cpha ? bit_i : bit_i + 1;                 // Bit being prepared
            if (nxt >= nbits) begin
                idx  = lsb ? (nxt - nbits) : (2 * nbits - 1 - nxt);
                dval = PATTERN[idx & 31];
                if (!oe) begin
                    // Master bridge lets go one clk after its last toggle
                    if (!cpha) begin
                        #60;
                    end
                    oe = (ss == 1'b0);
                end
            end
        end
    endtask

    initial begin
        capture = '0;
        oe      = 1'b0;
        dval    = 1'b0;
        edges   = 0;
        ss_q    = 1'b1;
        sck_q   = 1'b0;
        forever begin
            if ((ss === ss_q) && (sck === sck_q)) begin
                @(ss or sck);
                #1;                     // SS and SCK may both move on one config write
            end
            if (ss !== ss_q) begin
                ss_q  = ss;             // New frame or end of frame
                sck_q = sck;
                edges = 0;
                oe    = 1'b0;
                if (!ss) begin
                    capture = '0;
                end
            end else if (sck !== sck_q) begin
                sck_q = sck;
                if (!ss) begin
                    #10;
                    take_edge();
                end
            end
        end
    end

endmodule

// File: testbench/tb_spi_dio_pack.sv
`include "spi_dio_params.svh"

module tb_spi_dio_pack
    import spi_dio_pkg::*;
();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int    MAX_CYCLES    = 20000;
    localparam int    MAX_POLLS     = 300;
    localparam word_t CFG_RESET     = `SPI_CFG_RESET;
    localparam word_t DATA_ADDR     = {`SPI_BASE_ADDR, 24'h00_0000};
    localparam word_t CFG_ADDR      = DATA_ADDR + 32'd4;
    localparam word_t SLAVE_PATTERN = 32'hA5C3_0F96;

    logic     clk      = 1'b0;
    logic     rst_n    = 1'b0;
    mem_fwd_t mem_fwd  = '0;
    mem_ret_t mem_ret;
    logic     spi_ss;
    logic     spi_sck;
    wire      spi_dio;

    // Slave setup, mirrors the config register
    logic s_cpol  = 1'b0;
    logic s_cpha  = 1'b0;
    logic s_lsb   = 1'b0;
    int   s_nbits = 8;

    int   seed       = 88777;
    int   err_cnt    = 0;           // Sequence checks
    int   mon_err    = 0;           // Clocked monitor
    int   cycles     = 0;
    int   exp_div    = 0;
    int   run        = 0;           // Cycles at the current SCK level
    int   ss_low     = 0;           // Cycles with spi_ss low
    logic man_mode   = 1'b0;        // Manual SS, SS low time not checked
    logic auto_low   = 1'b0;        // SS fell under automatic control
    logic chk_sck    = 1'b0;
    logic read_phase = 1'b0;
    logic ready_p    = 1'b0;
    logic ss_p       = 1'b1;
    logic sck_p      = 1'b0;

    spi_dio_pack u_dut (
        .clk     (clk),
        .rst_n   (rst_n),
        .mem_fwd (mem_fwd),
        .mem_ret (mem_ret),
        .spi_ss  (spi_ss),
        .spi_sck (spi_sck),
        .spi_dio (spi_dio)
    );

    spi_dio_slave u_slave (
        .ss    (spi_ss),
        .sck   (spi_sck),
        .dio   (spi_dio),
        .cpol  (s_cpol),
        .cpha  (s_cpha),
        .lsb   (s_lsb),
        .nbits (s_nbits)
    );

    initial begin
        forever #20 clk = ~clk;     // 40 ns period
    end

    // ----------------------------------------
    // Helpers
    // ----------------------------------------
    task automatic apply_reset();
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
    endtask

    // One bus access, valid held until ready
    task automatic bus_access(input word_t addr, input word_t wdata, input logic [3:0] wstrb,
                              output word_t rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        mem_fwd <= '{valid: 1'b1, wstrb: wstrb, addr: addr, wdata: wdata};
        do begin
            @(posedge clk);
            waited++;
        end while (!mem_ret.ready && (waited < 16));
        assert (mem_ret.ready) else begin
            $display("No ready from the peripheral at address %h", addr);
            err_cnt++;
        end
        rdata = mem_ret.rdata;
        mem_fwd <= '0;
    endtask

    task automatic expect_word(input string what, input word_t got, input word_t exp);
        assert (got === exp) else begin
            $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, exp);
            err_cnt++;
        end
    endtask

    function automatic word_t mask_bits(input int n);
        word_t m;
        if (n >= 32) begin
            m = '1;
        end else begin
            m = (word_t'(1) << n) - word_t'(1);
        end
        return m;
    endfunction

    // Writes the config register and sets up the slave to match
    task automatic configure(input logic cpol, input logic cpha, input logic lsb,
                             input int d, input int n, input logic man, input logic ctrl);
        spi_cfg_t c;
        word_t    rd;
        c         = '0;
        c.clk_div = sck_div_t'(d);
        c.nbits   = nbits_t'(n);
        c.cpol    = cpol;
        c.cpha    = cpha;
        c.lsb     = lsb;
        c.ss_man  = man;
        c.ss_ctrl = ctrl;
        s_cpol    = cpol;
        s_cpha    = cpha;
        s_lsb     = lsb;
        s_nbits   = n;
        exp_div   = d;
        if (man) begin
            man_mode = 1'b1;
        end
        bus_access(CFG_ADDR, word_t'(c), 4'hF, rd);
        if (!man) begin
            man_mode = 1'b0;
        end
    endtask

    // Polls busy in the config register
    task automatic wait_idle();
        word_t st;
        int    polls;
        polls = 0;
        do begin
            bus_access(CFG_ADDR, '0, 4'h0, st);
            polls++;
        end while (st[30] && (polls < MAX_POLLS));
        assert (!st[30]) else begin
            $display("Engine still busy after %0d polls", polls);
            err_cnt++;
        end
    endtask

    task automatic probe_outside();
        int hits;
        hits = 0;
        @(posedge clk);
        mem_fwd <= '{valid: 1'b1, wstrb: 4'h0, addr: 32'h1000_0004, wdata: '0};
        repeat (8) begin
            @(posedge clk);
            if (mem_ret.ready) begin
                hits++;
            end
        end
        mem_fwd <= '0;
        assert (hits == 0) else begin
            $display("ERROR at %0t ns: %0d ready pulses outside the window", $time, hits);
            err_cnt++;
        end
    endtask

    // ----------------------------------------
    // Clocked monitor and timeout
    // ----------------------------------------
    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("Timeout: test did not finish within %0d clock cycles", MAX_CYCLES);
            $display("Simulation failed");
            $finish;
        end else begin
            if (rst_n) begin
                assert (!(mem_ret.ready && ready_p)) else begin
                    $display("ERROR at %0t ns: ready high two cycles in a row", $time);
                    mon_err++;
                end
                // Lead, 2n edges and trail give 2n+1 half periods
                if (auto_low && !ss_p && spi_ss) begin
                    assert (ss_low == (2 * s_nbits + 1) * (exp_div + 1)) else begin
                        $display("ERROR at %0t ns: spi_ss low for %0d cycles, expected %0d",
                                 $time, ss_low, (2 * s_nbits + 1) * (exp_div + 1));
                        mon_err++;
                    end
                end
                if (read_phase) begin
                    assert (spi_dio !== 1'bx) else begin
                        $display("ERROR at %0t ns: spi_dio is X in read phase", $time);
                        mon_err++;
                    end
                end
                if (chk_sck && !spi_ss && !ss_p && (spi_sck != sck_p)) begin
                    assert (run == exp_div + 1) else begin
                        $display("ERROR at %0t ns: SCK level lasted %0d cycles, expected %0d",
                                 $time, run, exp_div + 1);
                        mon_err++;
                    end
                end
            end
            if (ss_p && !spi_ss) begin
                run = 1;                // Lead level starts
            end else if (spi_sck != sck_p) begin
                run = 1;
            end else begin
                run++;
            end
            if (ss_p && !spi_ss) begin
                auto_low = !man_mode;
            end
            if (spi_ss) begin
                ss_low = 0;
            end else begin
                ss_low++;
            end
            ready_p = mem_ret.ready;
            ss_p    = spi_ss;
            sck_p   = spi_sck;
        end
    end

    // ----------------------------------------
    // Stimulus
    // ----------------------------------------
    initial begin
        word_t rd;
        word_t data;
        int    n;
        apply_reset();

        // After reset
        expect_word("spi_ss after reset", {31'b0, spi_ss}, 32'd1);
        expect_word("spi_sck after reset", {31'b0, spi_sck}, 32'd0);
        bus_access(CFG_ADDR, '0, 4'h0, rd);
        expect_word("config after reset", {1'b0, rd[30:0]}, {1'b0, CFG_RESET[30:0]});
        bus_access(DATA_ADDR, '0, 4'h0, rd);
        expect_word("data after reset", rd, '0);
        probe_outside();

        // Config readback, bits 31:30 are live
        man_mode = 1'b1;
        data = $random(seed);
        bus_access(CFG_ADDR, data, 4'hF, rd);
        bus_access(CFG_ADDR, '0, 4'h0, rd);
        expect_word("config bits 29:0", {2'b0, rd[29:0]}, {2'b0, data[29:0]});
        expect_word("idle busy bit", {31'b0, rd[30]}, '0);
        configure(1'b0, 1'b0, 1'b0, 0, 8, 1'b0, 1'b1);

        // Write-only transfers, mode 0 MSB first then mode 3 LSB first
        for (int m = 0; m < 2; m++) begin
            for (int k = 0; k < 2; k++) begin
                n = ($random(seed) & 31) + 1;
                configure(m[0], m[0], m[0], 0, n, 1'b0, 1'b1);
                data = $random(seed);
                bus_access(DATA_ADDR, data, 4'hF, rd);
                wait_idle();
                expect_word("captured word", u_slave.capture, data & mask_bits(n));
                expect_word("idle SCK", {31'b0, spi_sck}, {31'b0, m[0]});
            end
        end

        // SCK half periods, second start while busy is dropped
        for (int t = 0; t < 2; t++) begin
            n = ($random(seed) & 15) + 17;
            configure(1'b0, 1'b0, 1'b0, t * 3, n, 1'b0, 1'b1);
            chk_sck = 1'b1;
            data = $random(seed);
            bus_access(DATA_ADDR, data, 4'hF, rd);
            bus_access(DATA_ADDR, ~data, 4'hF, rd);
            wait_idle();
            chk_sck = 1'b0;
            expect_word("capture after ignored start", u_slave.capture, data & mask_bits(n));
        end

        // Command then read under manual SS, then SS level control
        for (int m = 0; m < 2; m++) begin
            n = ($random(seed) & 31) + 1;
            configure(m[0], m[0], m[0], m, n, 1'b1, 1'b0);
            data = $random(seed);
            bus_access(DATA_ADDR, data, 4'hF, rd);
            wait_idle();
            expect_word("command capture", u_slave.capture, data & mask_bits(n));
            read_phase = 1'b1;
            bus_access(DATA_ADDR, '0, 4'hF, rd);
            wait_idle();
            read_phase = 1'b0;
            bus_access(DATA_ADDR, '0, 4'h0, rd);
            expect_word("read-phase data", rd, SLAVE_PATTERN & mask_bits(n));
            bus_access(CFG_ADDR, '0, 4'h0, rd);
            expect_word("config MISO bit", {31'b0, rd[31]}, {31'b0, u_slave.dval});
            configure(m[0], m[0], m[0], m, n, 1'b1, 1'b1);
            expect_word("manual SS high", {31'b0, spi_ss}, 32'd1);
            configure(m[0], m[0], m[0], m, n, 1'b1, 1'b0);
            expect_word("manual SS low", {31'b0, spi_ss}, 32'd0);
            configure(m[0], m[0], m[0], m, n, 1'b1, 1'b1);
            expect_word("manual SS high again", {31'b0, spi_ss}, 32'd1);
            configure(1'b0, 1'b0, 1'b0, 0, 8, 1'b0, 1'b1);
        end

        repeat (4) @(posedge clk);
        $display("Test end: %0d errors (%0d sequence, %0d monitor)", err_cnt + mon_err,
                 err_cnt, mon_err);
        if (err_cnt + mon_err == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
